/* common/isaPkg.sv */
package isaPkg;

   // R format opcodes, 11 bits
   localparam logic [10:0] opAdds  = 11'b10101011000;
   localparam logic [10:0] opSubs  = 11'b11101011000;
   localparam logic [10:0] opAnd   = 11'b10001010000;
   localparam logic [10:0] opOrr   = 11'b10101010000;
   localparam logic [10:0] opEor   = 11'b11001010000;

   // D format opcodes, 11 bits
   localparam logic [10:0] opLdur  = 11'b11111000010;
   localparam logic [10:0] opStur  = 11'b11111000000;
   localparam logic [10:0] opLdurb = 11'b00111000010;
   localparam logic [10:0] opSturb = 11'b00111000000;

   // I format opcodes, 10 bits
   localparam logic [9:0]  opAddi  = 10'b1001000100;
   localparam logic [9:0]  opSubi  = 10'b1101000100;

   // IW format opcodes, 9 bits
   localparam logic [8:0]  opMovz  = 9'b110100101;
   localparam logic [8:0]  opMovk  = 9'b111100101;

   // XZR, reads as zero and ignores writes
   localparam logic [4:0]  zeroReg = 5'd31;

   typedef struct packed {
      logic [10:0] opcode;
      logic [4:0]  rm;
      logic [5:0]  shamt;
      logic [4:0]  rn;
      logic [4:0]  rd;
   } rFmt_t;

   typedef struct packed {
      logic [9:0]  opcode;
      logic [11:0] imm12;
      logic [4:0]  rn;
      logic [4:0]  rd;
   } iFmt_t;

   typedef struct packed {
      logic [10:0] opcode;
      logic [8:0]  daddr9;
      logic [1:0]  op2;
      logic [4:0]  rn;
      logic [4:0]  rt;
   } dFmt_t;

   typedef struct packed {
      logic [8:0]  opcode;
      logic [1:0]  hw;
      logic [15:0] imm16;
      logic [4:0]  rd;
   } iwFmt_t;

   // One instruction word seen through each format
   typedef union packed {
      rFmt_t  rFmt;
      iFmt_t  iFmt;
      dFmt_t  dFmt;
      iwFmt_t iwFmt;
   } instrWord_t;

endpackage

/* common/pipePkg.sv */
package pipePkg;

   // Byte address width of the data memory
   localparam int memAddrBits = 9;

   typedef enum logic [2:0] {
      aluPassB = 3'd0,
      aluAdd   = 3'd1,
      aluSub   = 3'd2,
      aluAnd   = 3'd3,
      aluOr    = 3'd4,
      aluXor   = 3'd5
   } aluOp_t;

   // Source of ALU operand B
   typedef enum logic [2:0] {
      srcReg    = 3'd0,
      srcDaddr9 = 3'd1,
      srcImm12  = 3'd2,
      srcMovk   = 3'd3,
      srcMovz   = 3'd4
   } srcB_t;

   typedef struct packed {
      aluOp_t aluOp;
      srcB_t  srcB;
      logic   regWrite;
      logic   memWrite;
      logic   memRead;
      logic   setFlags;
      logic   xferByte;
      logic   memToReg;
   } ctrl_t;

   // Decode to execute register
   typedef struct packed {
      logic        valid;
      ctrl_t       ctrl;
      logic [4:0]  rd;
      logic [4:0]  rn;
      logic [4:0]  rm;
      logic [63:0] regA;
      logic [63:0] regB;
      logic [63:0] imm64;
      logic [1:0]  hw;
   } idEx_t;

   // Execute to memory register
   typedef struct packed {
      logic        valid;
      ctrl_t       ctrl;
      logic [4:0]  rd;
      logic [63:0] aluResult;
      logic [63:0] storeData;
   } exMem_t;

   typedef struct packed {
      logic negative;
      logic zero;
      logic overflow;
      logic carry;
   } flags_t;

endpackage

/* execute/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import pipePkg::*; (
   input  logic [63:0] a,
   input  logic [63:0] b,
   input  aluOp_t      op,
   output logic [63:0] result,
   output flags_t      flagsOut
);

   logic        subtract;
   logic        isArith;
   logic [63:0] bEff;
   logic [64:0] sum;

   // Subtract as a + ~b + 1, carry out then means no borrow
   assign subtract = (op == aluSub);
   assign isArith  = (op == aluAdd) || (op == aluSub);
   assign bEff     = subtract ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, bEff} + {64'b0, subtract};

   always_comb begin
      case (op)
         aluAdd, aluSub: result = sum[63:0];
         aluAnd:         result = a & b;
         aluOr:          result = a | b;
         aluXor:         result = a ^ b;
         default:        result = b;
      endcase
   end

   always_comb begin
      flagsOut.negative = result[63];
      flagsOut.zero     = (result == '0);
      flagsOut.carry    = isArith && sum[64];
      // Signed overflow: same-sign inputs, result sign differs
      flagsOut.overflow = isArith && (a[63] == bEff[63]) && (sum[63] != a[63]);
   end

endmodule

/* execute/executeStage.sv */
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipePkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  idEx_t       idEx,
   input  logic        fwdValid,
   input  logic [4:0]  fwdReg,
   input  logic [63:0] fwdData,
   output exMem_t      exMem,
   output flags_t      flags
);

   logic        fwdA;
   logic        fwdB;
   logic [63:0] opA;
   logic [63:0] opB;
   logic [5:0]  distance;
   logic [63:0] shiftedImm;
   logic [63:0] fieldMask;
   logic [63:0] operandB;
   logic [63:0] aluResult;
   flags_t      aluFlags;

   // Writeback value of the instruction in MEM, XZR excluded
   assign fwdA = fwdValid && (fwdReg == idEx.rn) && (idEx.rn != zeroReg);
   assign fwdB = fwdValid && (fwdReg == idEx.rm) && (idEx.rm != zeroReg);
   assign opA  = fwdA ? fwdData : idEx.regA;
   assign opB  = fwdB ? fwdData : idEx.regB;

   // hw times 16
   assign distance   = {idEx.hw, 4'b0};
   assign shiftedImm = idEx.imm64 << distance;
   assign fieldMask  = 64'hFFFF << distance;

   always_comb begin
      case (idEx.ctrl.srcB)
         srcDaddr9, srcImm12: operandB = idEx.imm64;
         // Clear the selected halfword, then drop in imm16
         srcMovk:             operandB = (opB & ~fieldMask) | shiftedImm;
         srcMovz:             operandB = shiftedImm;
         default:             operandB = opB;
      endcase
   end

   aluUnit u_alu (
      .a        (opA),
      .b        (operandB),
      .op       (idEx.ctrl.aluOp),
      .result   (aluResult),
      .flagsOut (aluFlags)
   );

   always_comb begin
      exMem.valid     = idEx.valid;
      exMem.ctrl      = idEx.ctrl;
      exMem.rd        = idEx.rd;
      exMem.aluResult = aluResult;
      // Store data after forwarding
      exMem.storeData = opB;
   end

   // Only ADDS and SUBS move the flags
   always_ff @(posedge clk) begin
      if (!rstN) begin
         flags <= '0;
      end else if (idEx.valid && idEx.ctrl.setFlags) begin
         flags <= aluFlags;
      end
   end

endmodule

/* logic/dataMem.sv */
`timescale 1ns/1ps

module dataMem import pipePkg::*; (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic [memAddrBits-1:0] addr,
   input  logic                   wrEn,
   input  logic                   byteXfer,
   input  logic [63:0]            wrData,
   output logic [63:0]            rdData
);

   logic [7:0] mem [0:(1 << memAddrBits) - 1];

   // Little-endian, byte 0 of the doubleword at the lowest address
   always_comb begin
      if (byteXfer) begin
         // LDURB zero-extends
         rdData = {56'b0, mem[addr]};
      end else begin
         for (int k = 0; k < 8; k++) begin
            rdData[8*k +: 8] = mem[{addr[memAddrBits-1:3], 3'(k)}];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < (1 << memAddrBits); i++) begin
            mem[i] <= '0;
         end
      end else if (wrEn) begin
         if (byteXfer) begin
            mem[addr] <= wrData[7:0];
         end else begin
            for (int k = 0; k < 8; k++) begin
               mem[{addr[memAddrBits-1:3], 3'(k)}] <= wrData[8*k +: 8];
            end
         end
      end
   end

   // Doubleword stores must sit on an 8-byte boundary
   assert property (@(posedge clk) disable iff (!rstN)
      (wrEn && !byteXfer) |-> (addr[2:0] == 3'b000))
      else $error("dataMem: unaligned doubleword store at %h", addr);

endmodule

/* logic/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode import isaPkg::*, pipePkg::*; (
   input  instrWord_t  instr,
   input  logic        instrValid,
   output ctrl_t       ctrl,
   output logic [4:0]  rnSel,
   output logic [4:0]  rmSel,
   output logic [4:0]  rdSel,
   output logic [63:0] imm64,
   output logic [1:0]  hw
);

   logic known;

   always_comb begin
      // Defaults follow the R format view
      ctrl  = '0;
      known = 1'b1;
      rnSel = instr.rFmt.rn;
      rmSel = instr.rFmt.rm;
      rdSel = instr.rFmt.rd;
      imm64 = '0;
      hw    = instr.iwFmt.hw;

      case (instr.rFmt.opcode)
         opAdds, opSubs: begin
            ctrl.aluOp    = (instr.rFmt.opcode == opAdds) ? aluAdd : aluSub;
            ctrl.setFlags = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         opAnd, opOrr, opEor: begin
            ctrl.aluOp    = (instr.rFmt.opcode == opAnd) ? aluAnd :
                            (instr.rFmt.opcode == opOrr) ? aluOr : aluXor;
            ctrl.regWrite = 1'b1;
         end
         opLdur, opLdurb, opStur, opSturb: begin
            // Base plus sign-extended offset
            ctrl.aluOp    = aluAdd;
            ctrl.srcB     = srcDaddr9;
            ctrl.xferByte = (instr.dFmt.opcode == opLdurb) || (instr.dFmt.opcode == opSturb);
            imm64         = {{55{instr.dFmt.daddr9[8]}}, instr.dFmt.daddr9};
            rdSel         = instr.dFmt.rt;
            if ((instr.dFmt.opcode == opLdur) || (instr.dFmt.opcode == opLdurb)) begin
               ctrl.memRead  = 1'b1;
               ctrl.memToReg = 1'b1;
               ctrl.regWrite = 1'b1;
               rmSel         = zeroReg;
            end else begin
               // Store data comes in through the second read port
               ctrl.memWrite = 1'b1;
               rmSel         = instr.dFmt.rt;
            end
         end
         default: begin
            case (instr.iFmt.opcode)
               opAddi, opSubi: begin
                  ctrl.aluOp    = (instr.iFmt.opcode == opAddi) ? aluAdd : aluSub;
                  ctrl.srcB     = srcImm12;
                  ctrl.regWrite = 1'b1;
                  imm64         = {52'b0, instr.iFmt.imm12};
                  rmSel         = zeroReg;
               end
               default: begin
                  imm64 = {48'b0, instr.iwFmt.imm16};
                  rnSel = zeroReg;
                  ctrl.aluOp    = aluPassB;
                  ctrl.regWrite = 1'b1;
                  if (instr.iwFmt.opcode == opMovz) begin
                     ctrl.srcB = srcMovz;
                     rmSel     = zeroReg;
                  end else if (instr.iwFmt.opcode == opMovk) begin
                     // Old rd value is merged, read it as operand B
                     ctrl.srcB = srcMovk;
                     rmSel     = instr.iwFmt.rd;
                  end else begin
                     known = 1'b0;
                  end
               end
            endcase
         end
      endcase

      // No side effects from a bubble or an undefined word
      if (!(instrValid && known)) begin
         ctrl = '0;
      end

      assert final (instrValid !== 1'b1 || known)
         else $error("instrDecode: unknown opcode in word %h", instr);
   end

endmodule

/* logic/legCore.sv */
`timescale 1ns/1ps

module legCore import isaPkg::*, pipePkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  instrWord_t  instr,
   input  logic        instrValid,
   output logic        retValid,
   output logic        retWrite,
   output logic [4:0]  retReg,
   output logic [63:0] retData,
   output flags_t      flags
);

   ctrl_t       decCtrl;
   logic [4:0]  rnSel;
   logic [4:0]  rmSel;
   logic [4:0]  rdSel;
   logic [63:0] decImm;
   logic [1:0]  decHw;
   logic [63:0] rdDataA;
   logic [63:0] rdDataB;
   idEx_t       idExNext;
   idEx_t       idEx;
   exMem_t      exMemNext;
   exMem_t      exMem;
   logic        wbEn;
   logic        memWrEn;
   logic [63:0] memRdData;
   logic [63:0] loadData;
   logic [63:0] wbData;

   // ID stage
   instrDecode u_decode (
      .instr      (instr),
      .instrValid (instrValid),
      .ctrl       (decCtrl),
      .rnSel      (rnSel),
      .rmSel      (rmSel),
      .rdSel      (rdSel),
      .imm64      (decImm),
      .hw         (decHw)
   );

   regFile u_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (rnSel),
      .rdAddrB (rmSel),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wbEn),
      .wrAddr  (exMem.rd),
      .wrData  (wbData)
   );

   always_comb begin
      idExNext.valid = instrValid;
      idExNext.ctrl  = decCtrl;
      idExNext.rd    = rdSel;
      idExNext.rn    = rnSel;
      idExNext.rm    = rmSel;
      idExNext.regA  = rdDataA;
      idExNext.regB  = rdDataB;
      idExNext.imm64 = decImm;
      idExNext.hw    = decHw;
   end

   // Payload fields hold during reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         idEx.valid <= 1'b0;
         idEx.ctrl  <= '0;
      end else begin
         idEx <= idExNext;
      end
   end

   // EX stage, forwarding taken from the writeback value
   executeStage u_execute (
      .clk      (clk),
      .rstN     (rstN),
      .idEx     (idEx),
      .fwdValid (wbEn),
      .fwdReg   (exMem.rd),
      .fwdData  (wbData),
      .exMem    (exMemNext),
      .flags    (flags)
   );

   always_ff @(posedge clk) begin
      if (!rstN) begin
         exMem.valid <= 1'b0;
         exMem.ctrl  <= '0;
      end else begin
         exMem <= exMemNext;
      end
   end

   // MEM and writeback
   assign wbEn    = exMem.valid && exMem.ctrl.regWrite;
   assign memWrEn = exMem.valid && exMem.ctrl.memWrite;

   dataMem u_dataMem (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (exMem.aluResult[memAddrBits-1:0]),
      .wrEn     (memWrEn),
      .byteXfer (exMem.ctrl.xferByte),
      .wrData   (exMem.storeData),
      .rdData   (memRdData)
   );

   assign loadData = exMem.ctrl.memRead ? memRdData : '0;
   assign wbData   = exMem.ctrl.memToReg ? loadData : exMem.aluResult;

   // Retire record, one per completed instruction
   always_ff @(posedge clk) begin
      if (!rstN) begin
         retValid <= 1'b0;
         retWrite <= 1'b0;
      end else begin
         retValid <= exMem.valid;
         retWrite <= wbEn;
      end
      retReg  <= exMem.rd;
      retData <= wbData;
   end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile import isaPkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  logic [4:0]  rdAddrA,
   input  logic [4:0]  rdAddrB,
   output logic [63:0] rdDataA,
   output logic [63:0] rdDataB,
   input  logic        wrEn,
   input  logic [4:0]  wrAddr,
   input  logic [63:0] wrData
);

   // X0 to X30, XZR has no storage
   logic [63:0] regs [0:30];

   // Write-through so a reader sees the value landing at this edge
   function automatic logic [63:0] readPort(input logic [4:0] addr);
      logic [63:0] value;
      if (addr == zeroReg) begin
         value = '0;
      end else if (wrEn && (wrAddr == addr)) begin
         value = wrData;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   always_comb begin
      rdDataA = readPort(rdAddrA);
      rdDataB = readPort(rdAddrB);
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 31; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrAddr != zeroReg)) begin
         regs[wrAddr] <= wrData;
      end
   end

   // A write to XZR leaves a steady read unchanged on the next cycle
   assert property (@(posedge clk) disable iff (!rstN)
      (wrEn && (wrAddr == zeroReg))
      |=> (rdAddrA != $past(rdAddrA)) || (wrEn && (wrAddr == rdAddrA)) ||
          (rdDataA == $past(rdDataA)))
      else $error("regFile: write to XZR changed a read value");

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the legCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module legCoreTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/VlegCoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1

/* test/legRefModel.svh */
`ifndef LEG_REF_MODEL_SVH
`define LEG_REF_MODEL_SVH

// Expected retire record, also carries the flags after the instruction
typedef struct packed {
   logic [31:0] acceptEdge;
   logic        write;
   logic [4:0]  dest;
   logic [63:0] data;
   flags_t      flags;
} retireRec_t;

// Architectural state of the model
logic [63:0] modelRegs [0:31];
logic [7:0]  modelMem [0:511];
flags_t      modelFlags;

// XZR reads as zero
function automatic logic [63:0] modelRead(input logic [4:0] r);
   return (r == 5'd31) ? 64'd0 : modelRegs[r];
endfunction

// Executes one word on the model state and returns what should retire
function automatic retireRec_t applyInstr(input logic [31:0] word);
   retireRec_t  rec;
   logic [63:0] a;
   logic [63:0] b;
   logic [63:0] res;
   logic [63:0] imm;
   logic [63:0] mask;
   logic [8:0]  addr;
   logic [5:0]  sh;
   int          k;
   rec       = '0;
   rec.dest  = word[4:0];
   rec.write = 1'b1;
   a         = modelRead(word[9:5]);
   b         = modelRead(word[20:16]);
   sh        = {word[22:21], 4'b0};
   imm       = {48'b0, word[20:5]} << sh;
   res       = '0;
   if (word[31:21] == opAdds || word[31:21] == opSubs) begin
      if (word[31:21] == opAdds) begin
         res = a + b;
         // Carry when the unsigned sum wraps
         modelFlags.carry    = (res < a);
         modelFlags.overflow = (a[63] == b[63]) && (res[63] != a[63]);
      end else begin
         res = a - b;
         // Carry set means no borrow
         modelFlags.carry    = (a >= b);
         modelFlags.overflow = (a[63] != b[63]) && (res[63] != a[63]);
      end
      modelFlags.negative = res[63];
      modelFlags.zero     = (res == 64'd0);
   end else if (word[31:21] == opAnd) begin
      res = a & b;
   end else if (word[31:21] == opOrr) begin
      res = a | b;
   end else if (word[31:21] == opEor) begin
      res = a ^ b;
   end else if (word[31:21] == opLdur || word[31:21] == opLdurb ||
                word[31:21] == opStur || word[31:21] == opSturb) begin
      // Base plus signed 9-bit offset, memory wraps at 512 bytes
      res  = a + {{55{word[20]}}, word[20:12]};
      addr = res[8:0];
      b    = modelRead(word[4:0]);
      if (word[31:21] == opStur) begin
         rec.write = 1'b0;
         for (k = 0; k < 8; k++) begin
            modelMem[addr + k] = b[8*k +: 8];
         end
      end else if (word[31:21] == opSturb) begin
         rec.write      = 1'b0;
         modelMem[addr] = b[7:0];
      end else if (word[31:21] == opLdurb) begin
         res = {56'b0, modelMem[addr]};
      end else begin
         // Little endian doubleword
         for (k = 0; k < 8; k++) begin
            res[8*k +: 8] = modelMem[addr + k];
         end
      end
   end else if (word[31:22] == opAddi) begin
      res = a + {52'b0, word[21:10]};
   end else if (word[31:22] == opSubi) begin
      res = a - {52'b0, word[21:10]};
   end else if (word[31:23] == opMovz) begin
      res = imm;
   end else begin
      // MOVK keeps the other three halfwords of rd
      mask = 64'hFFFF << sh;
      res  = (modelRead(word[4:0]) & ~mask) | imm;
   end
   if (rec.write && rec.dest != 5'd31) begin
      modelRegs[rec.dest] = res;
   end
   rec.data  = res;
   rec.flags = modelFlags;
   return rec;
endfunction

`endif

/* test/legCoreTb.sv */
`timescale 1ns/1ps

module legCoreTb import isaPkg::*, pipePkg::*; ();

   logic        clk;
   logic        rstN;
   instrWord_t  instr;
   logic        instrValid;
   logic        retValid;
   logic        retWrite;
   logic [4:0]  retReg;
   logic [63:0] retData;
   flags_t      flags;

   `include "legRefModel.svh"

   retireRec_t  expQ [$];
   retireRec_t  flagQ [$];
   retireRec_t  headRec;
   flags_t      expFlags = '0;
   int          edgeCount = 0;
   int          errors = 0;
   int          checks = 0;
   int          seed = 32'haa3c5719;

   legCore u_dut (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .instrValid (instrValid),
      .retValid   (retValid),
      .retWrite   (retWrite),
      .retReg     (retReg),
      .retData    (retData),
      .flags      (flags)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Rising edges since time zero
   always @(posedge clk) begin
      edgeCount <= edgeCount + 1;
   end

   task automatic checkValue(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] encodeR(input logic [10:0] op, input logic [4:0] rm,
                                           input logic [4:0] rn, input logic [4:0] rd);
      return {op, rm, 6'd0, rn, rd};
   endfunction

   function automatic logic [31:0] encodeI(input logic [9:0] op, input logic [11:0] imm12,
                                           input logic [4:0] rn, input logic [4:0] rd);
      return {op, imm12, rn, rd};
   endfunction

   function automatic logic [31:0] encodeD(input logic [10:0] op, input logic [8:0] daddr9,
                                           input logic [4:0] rn, input logic [4:0] rt);
      return {op, daddr9, 2'b00, rn, rt};
   endfunction

   function automatic logic [31:0] encodeIW(input logic [8:0] op, input logic [1:0] hw,
                                            input logic [15:0] imm16, input logic [4:0] rd);
      return {op, hw, imm16, rd};
   endfunction

   // Accepted one edge after it is driven
   task automatic issueInstr(input logic [31:0] word);
      retireRec_t rec;
      @(posedge clk);
      rec            = applyInstr(word);
      rec.acceptEdge = edgeCount + 2;
      expQ.push_back(rec);
      flagQ.push_back(rec);
      instr      <= word;
      instrValid <= 1'b1;
   endtask

   task automatic insertBubble();
      @(posedge clk);
      instr      <= '0;
      instrValid <= 1'b0;
   endtask

   // X0 to X3 or XZR, so dependencies are frequent
   task automatic pickReg(output logic [4:0] r);
      logic [31:0] v;
      v = $random(seed);
      r = (v[2:0] == 3'd7) ? 5'd31 : {3'b0, v[1:0]};
   endtask

   // X10 holds 256, so any signed offset stays inside memory
   task automatic randomInstr();
      logic [31:0] v;
      logic [4:0]  rd;
      logic [4:0]  rn;
      logic [4:0]  rm;
      logic [8:0]  off;
      v = $random(seed);
      pickReg(rd);
      pickReg(rn);
      pickReg(rm);
      off = v[20:12];
      case (v[31:24] % 13)
         0:       issueInstr(encodeR(opAdds, rm, rn, rd));
         1:       issueInstr(encodeR(opSubs, rm, rn, rd));
         2:       issueInstr(encodeR(opAnd, rm, rn, rd));
         3:       issueInstr(encodeR(opOrr, rm, rn, rd));
         4:       issueInstr(encodeR(opEor, rm, rn, rd));
         5:       issueInstr(encodeI(opAddi, v[11:0], rn, rd));
         6:       issueInstr(encodeI(opSubi, v[11:0], rn, rd));
         7:       issueInstr(encodeD(opLdur, {off[8:3], 3'b0}, 5'd10, rd));
         8:       issueInstr(encodeD(opStur, {off[8:3], 3'b0}, 5'd10, rd));
         9:       issueInstr(encodeD(opLdurb, off, 5'd10, rd));
         10:      issueInstr(encodeD(opSturb, off, 5'd10, rd));
         11:      issueInstr(encodeIW(opMovz, v[1:0], v[27:12], rd));
         default: issueInstr(encodeIW(opMovk, v[1:0], v[27:12], rd));
      endcase
      if (v[5:3] == 3'd0) begin
         insertBubble();
      end
   endtask

   // Compare process, outputs are stable at the falling edge
   always @(negedge clk) begin
      if (rstN) begin
         // Flags follow each instruction one edge after acceptance
         while (flagQ.size() > 0 && flagQ[0].acceptEdge + 1 <= edgeCount) begin
            expFlags = flagQ[0].flags;
            void'(flagQ.pop_front());
         end
         checkValue("flags", 64'(flags), 64'(expFlags));
         // Retire record registered two edges after acceptance
         if (retValid) begin
            if (expQ.size() == 0) begin
               errors++;
               $display("Retire seen at time %0t with no instruction outstanding", $time);
            end else begin
               headRec = expQ.pop_front();
               checkValue("retire edge", 64'(edgeCount), 64'(headRec.acceptEdge + 2));
               checkValue("retWrite", 64'(retWrite), 64'(headRec.write));
               checkValue("retReg", 64'(retReg), 64'(headRec.dest));
               if (headRec.write) begin
                  checkValue("retData", retData, headRec.data);
               end
            end
         end else if (expQ.size() > 0 && expQ[0].acceptEdge + 2 <= edgeCount) begin
            errors++;
            $display("Instruction accepted at edge %0d never retired", expQ[0].acceptEdge);
            void'(expQ.pop_front());
         end
      end
   end

   initial begin
      int waitCycles;
      for (int r = 0; r < 32; r++) begin
         modelRegs[r] = '0;
      end
      for (int m = 0; m < 512; m++) begin
         modelMem[m] = '0;
      end
      modelFlags = '0;
      rstN       = 1'b0;
      instr      = '0;
      instrValid = 1'b0;
      repeat (2) @(posedge clk);
      rstN <= 1'b1;

      // Memory base, then reads of untouched memory
      issueInstr(encodeIW(opMovz, 2'd0, 16'h0100, 5'd10));
      issueInstr(encodeD(opLdur, 9'd16, 5'd10, 5'd1));
      issueInstr(encodeD(opLdurb, 9'd5, 5'd10, 5'd2));
      // MOVZ and MOVK over all four halfwords
      issueInstr(encodeIW(opMovz, 2'd3, 16'h8123, 5'd1));
      issueInstr(encodeIW(opMovk, 2'd0, 16'hABCD, 5'd1));
      issueInstr(encodeIW(opMovk, 2'd1, 16'h5566, 5'd1));
      issueInstr(encodeIW(opMovk, 2'd2, 16'h7788, 5'd1));
      issueInstr(encodeIW(opMovk, 2'd3, 16'h0F0F, 5'd1));
      issueInstr(encodeIW(opMovz, 2'd1, 16'hFFFF, 5'd2));
      issueInstr(encodeIW(opMovz, 2'd2, 16'h0042, 5'd3));
      // Doubleword store, load and immediate use
      issueInstr(encodeD(opStur, 9'h1F8, 5'd10, 5'd1));
      issueInstr(encodeD(opLdur, 9'h1F8, 5'd10, 5'd4));
      issueInstr(encodeR(opAdds, 5'd4, 5'd4, 5'd5));
      // Byte store into a zero doubleword
      issueInstr(encodeD(opSturb, 9'd3, 5'd10, 5'd1));
      issueInstr(encodeD(opLdurb, 9'd3, 5'd10, 5'd6));
      issueInstr(encodeD(opLdur, 9'd0, 5'd10, 5'd7));
      // Overflow and carry corners
      issueInstr(encodeIW(opMovz, 2'd3, 16'h8000, 5'd8));
      issueInstr(encodeR(opAdds, 5'd8, 5'd8, 5'd9));
      issueInstr(encodeR(opSubs, 5'd8, 5'd31, 5'd9));
      insertBubble();
      issueInstr(encodeR(opAnd, 5'd1, 5'd2, 5'd9));
      issueInstr(encodeR(opSubs, 5'd7, 5'd7, 5'd9));
      // XZR as destination then as source
      issueInstr(encodeI(opAddi, 12'd5, 5'd1, 5'd31));
      issueInstr(encodeR(opOrr, 5'd31, 5'd31, 5'd11));
      // Distance two across a bubble, then a chain
      issueInstr(encodeI(opSubi, 12'hFFF, 5'd11, 5'd12));
      insertBubble();
      issueInstr(encodeR(opEor, 5'd12, 5'd1, 5'd13));
      issueInstr(encodeI(opAddi, 12'd1, 5'd13, 5'd13));
      issueInstr(encodeI(opAddi, 12'd1, 5'd13, 5'd13));

      for (int i = 0; i < 300; i++) begin
         randomInstr();
      end
      insertBubble();

      // Drain the pipeline
      waitCycles = 0;
      while (expQ.size() > 0 && waitCycles < 20) begin
         @(posedge clk);
         waitCycles++;
      end
      if (expQ.size() > 0) begin
         errors++;
         $display("Timed out with %0d instructions still waiting to retire", expQ.size());
      end
      @(negedge clk);
      @(negedge clk);

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+test
common/isaPkg.sv
common/pipePkg.sv
logic/instrDecode.sv
logic/regFile.sv
execute/aluUnit.sv
execute/executeStage.sv
logic/dataMem.sv
logic/legCore.sv
test/legCoreTb.sv
